//--- logic/cpuPkg.sv
package cpuPkg;

    // Data path and address width
    typedef logic [31:0] word;

    // Register index
    typedef logic [4:0] regAddr;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opRType  = 7'b0110011,
        opIType  = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opLui    = 7'b0110111
    } opcode;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,  // Signed compare
        aluPassB = 4'd6   // Operand B straight through, for lui
    } aluOp;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immKind;

    // Register write-back source
    typedef enum logic [1:0] {
        wbAlu     = 2'd0,
        wbMem     = 2'd1,
        wbPcPlus4 = 2'd2
    } wbSel;

    // funct3 codes that the decoder accepts
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;  // lw and sw
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    localparam word resetPc  = 32'h0000_0000;
    localparam int  regCount = 32;

endpackage

//--- logic/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  cpuPkg::word    instr,
    input  logic           rstN,
    output logic           aluSrcImm,
    output logic           regWrite,
    output logic           memWrite,
    output logic           branch,
    output logic           branchOnNotEqual,
    output logic           jump,
    output cpuPkg::aluOp   aluOperation,
    output cpuPkg::immKind immFormat,
    output cpuPkg::wbSel   writeBackSel
);
    import cpuPkg::*;

    opcode      op;
    logic [2:0] funct3;
    logic       decRegWrite;  // Before reset gating
    logic       decMemWrite;

    assign op     = opcode'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        aluSrcImm        = 1'b0;
        aluOperation     = aluAdd;
        immFormat        = immI;
        writeBackSel     = wbAlu;
        decRegWrite      = 1'b0;
        decMemWrite      = 1'b0;
        branch           = 1'b0;
        branchOnNotEqual = 1'b0;
        jump             = 1'b0;
        case (op)
            opRType, opIType: begin
                aluSrcImm   = (op == opIType);
                decRegWrite = 1'b1;
                case (funct3)
                    // Bit 30 picks sub only for register operands
                    f3AddSub: aluOperation = (op == opRType && instr[30]) ? aluSub : aluAdd;
                    f3Slt:    aluOperation = aluSlt;
                    f3Xor:    aluOperation = aluXor;
                    f3Or:     aluOperation = aluOr;
                    f3And:    aluOperation = aluAnd;
                    default:  decRegWrite = 1'b0;  // Shifts, sltu and the like
                endcase
            end
            opLoad: begin
                aluSrcImm    = 1'b1;
                writeBackSel = wbMem;
                decRegWrite  = (funct3 == f3Word);
            end
            opStore: begin
                aluSrcImm   = 1'b1;
                immFormat   = immS;
                decMemWrite = (funct3 == f3Word);
            end
            opBranch: begin
                aluOperation     = aluSub;  // Equality via zero flag
                immFormat        = immB;
                branch           = (funct3 == f3Beq) || (funct3 == f3Bne);
                branchOnNotEqual = (funct3 == f3Bne);
            end
            opJal: begin
                immFormat    = immJ;
                writeBackSel = wbPcPlus4;
                decRegWrite  = 1'b1;
                jump         = 1'b1;
            end
            opLui: begin
                aluSrcImm    = 1'b1;
                aluOperation = aluPassB;
                immFormat    = immU;
                decRegWrite  = 1'b1;
            end
            default: ;  // Unsupported opcode runs as a no-op
        endcase
    end

    // No architectural writes during reset
    assign regWrite = decRegWrite & rstN;
    assign memWrite = decMemWrite & rstN;

    noStoreAndWriteBack: assert final (!(memWrite && regWrite))
        else $error("store and register write decoded together for %h", instr);

endmodule

//--- logic/immGen.sv
`timescale 1ns/100ps

module immGen (
    input  cpuPkg::word    instr,
    input  cpuPkg::immKind immFormat,
    output cpuPkg::word    imm
);
    import cpuPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFormat)
            immI: imm = {{20{sign}}, instr[31:20]};
            immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offsets are in halfwords, bit 0 always clear
            immB: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            immU:    imm = {instr[31:12], 12'h000};  // Upper 20 bits
            default: imm = '0;
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic           CLK,
    input  logic           rstN,
    input  logic           regWrite,
    input  cpuPkg::regAddr rs1,
    input  cpuPkg::regAddr rs2,
    input  cpuPkg::regAddr rd,
    input  cpuPkg::wbSel   writeBackSel,
    input  cpuPkg::word    aluResult,
    input  cpuPkg::word    memData,
    input  cpuPkg::word    pcPlus4,
    output cpuPkg::word    rs1Data,
    output cpuPkg::word    rs2Data
);
    import cpuPkg::*;

    word regs [regCount];
    word writeData;

    always_comb begin
        case (writeBackSel)
            wbMem:     writeData = memData;
            wbPcPlus4: writeData = pcPlus4;  // Link value for jal
            default:   writeData = aluResult;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin  // x0 never written
            regs[rd] <= writeData;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // x0 stays zero because reset clears it and writes skip it
    x0ReadsZero: assert property (
        @(posedge CLK) disable iff (!rstN) rs1 == '0 |-> rs1Data == '0
    ) else $error("x0 read returned %h", rs1Data);

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpuPkg::word  a,
    input  cpuPkg::word  b,
    input  cpuPkg::word  imm,
    input  logic         aluSrcImm,
    input  cpuPkg::aluOp aluOperation,
    output cpuPkg::word  result,
    output logic         zero
);
    import cpuPkg::*;

    word operandB;
    word difference;

    // Immediate replaces rs2 for I, load, store and lui
    assign operandB = aluSrcImm ? imm : b;

    assign difference = a - operandB;

    always_comb begin
        case (aluOperation)
            aluAdd:   result = a + operandB;
            aluSub:   result = difference;
            aluAnd:   result = a & operandB;
            aluOr:    result = a | operandB;
            aluXor:   result = a ^ operandB;
            aluSlt:   result = {31'b0, $signed(a) < $signed(operandB)};
            aluPassB: result = operandB;
            default:  result = '0;
        endcase
    end

    // Branch equality test
    assign zero = (result == '0);

    knownInKnownOut: assert final (
        $isunknown({a, operandB, aluOperation}) || !$isunknown(result)
    ) else $error("ALU result %h has unknown bits", result);

endmodule

//--- logic/pcUnit.sv
`timescale 1ns/100ps

module pcUnit (
    input  logic        CLK,
    input  logic        rstN,
    input  logic        branch,
    input  logic        branchOnNotEqual,
    input  logic        jump,
    input  logic        zero,
    input  cpuPkg::word imm,
    output cpuPkg::word pc,
    output cpuPkg::word pcPlus4
);
    import cpuPkg::*;

    word  target;
    logic taken;

    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + imm;  // Shared by branches and jal

    // bne flips the sense of the zero flag
    assign taken = jump | (branch & (zero ^ branchOnNotEqual));

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= taken ? target : pcPlus4;
        end
    end

    pcWordAligned: assert property (@(posedge CLK) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("misaligned PC %h", pc);

endmodule

//--- logic/singleCpu.sv
`timescale 1ns/100ps

module singleCpu (
    input  logic        CLK,
    input  logic        rstN,
    input  cpuPkg::word instr,
    input  cpuPkg::word dataRdata,
    output cpuPkg::word instrAddr,
    output cpuPkg::word dataAddr,
    output cpuPkg::word dataWdata,
    output logic        dataWe
);
    import cpuPkg::*;

    // Register fields of the current instruction
    regAddr rs1;
    regAddr rs2;
    regAddr rd;

    // Control
    logic   aluSrcImm;
    logic   regWrite;
    logic   branch;
    logic   branchOnNotEqual;
    logic   jump;
    aluOp   aluOperation;
    immKind immFormat;
    wbSel   writeBackSel;

    // Datapath
    word    imm;
    word    rs1Data;
    word    rs2Data;
    word    aluResult;
    logic   zero;
    word    pc;
    word    pcPlus4;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign instrAddr = pc;
    assign dataAddr  = aluResult;  // Load and store address
    assign dataWdata = rs2Data;

    controlUnit controlUnit_inst (
        .instr(instr),
        .rstN(rstN),
        .aluSrcImm(aluSrcImm),
        .regWrite(regWrite),
        .memWrite(dataWe),
        .branch(branch),
        .branchOnNotEqual(branchOnNotEqual),
        .jump(jump),
        .aluOperation(aluOperation),
        .immFormat(immFormat),
        .writeBackSel(writeBackSel)
    );

    immGen immGen_inst (.instr(instr), .immFormat(immFormat), .imm(imm));

    regFile regFile_inst (
        .CLK(CLK), .rstN(rstN), .regWrite(regWrite),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .writeBackSel(writeBackSel),
        .aluResult(aluResult), .memData(dataRdata), .pcPlus4(pcPlus4),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu alu_inst (
        .a(rs1Data), .b(rs2Data), .imm(imm), .aluSrcImm(aluSrcImm),
        .aluOperation(aluOperation), .result(aluResult), .zero(zero)
    );

    pcUnit pcUnit_inst (
        .CLK(CLK), .rstN(rstN),
        .branch(branch), .branchOnNotEqual(branchOnNotEqual), .jump(jump), .zero(zero),
        .imm(imm), .pc(pc), .pcPlus4(pcPlus4)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic CLK,
    output logic rstN
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    // Reset low for 10 cycles, released just after an edge
    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge CLK);
        #1 rstN = 1'b1;
    end

endmodule

//--- tb/singleCpuTb.sv
`timescale 1ns/100ps

module singleCpuTb;
    import cpuPkg::*;

    logic  CLK;
    logic  rstN;
    word   instr;
    word   dataRdata;
    word   instrAddr;
    word   dataAddr;
    word   dataWdata;
    logic  dataWe;

    word   rom [64];
    word   ram [64];
    word   nextPc [64];      // Where control goes after each ROM word
    word   expMem [64];      // Value each store must carry
    bit    expValid [64];
    bit    seen [64];
    int    testOfWord [64];
    string names [6] = '{"reset", "register arithmetic", "immediates", "branches",
                         "jal link", "x0 and unknown opcode"};
    word   testEnd [6];      // PC at which each test is complete
    int    errs [6];
    int    curTest;
    int    progLen;
    word   expNext;

    clockGen clockGen_inst (.CLK(CLK), .rstN(rstN));

    singleCpu singleCpu_inst (
        .CLK(CLK), .rstN(rstN), .instr(instr), .dataRdata(dataRdata),
        .instrAddr(instrAddr), .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe)
    );

    // Combinational reads, word addressed
    assign instr     = rom[instrAddr[7:2]];
    assign dataRdata = ram[dataAddr[7:2]];

    always @(posedge CLK) begin
        if (dataWe) begin
            ram[dataAddr[7:2]] <= dataWdata;
        end
    end

    // RV32I instruction formats
    function automatic word rFormat(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opRType};
    endfunction

    function automatic word iFormat(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word sFormat(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction

    function automatic word bFormat(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
    endfunction

    function automatic word jFormat(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    function automatic word uFormat(int imm20, int rd);
        return {imm20[19:0], rd[4:0], opLui};
    endfunction

    task automatic emit(word w);
        rom[progLen]    = w;
        nextPc[progLen] = (progLen + 1) * 4;
        progLen++;
    endtask

    // Instruction known to transfer control by offset
    task automatic emitTaken(word w, int offset);
        rom[progLen]    = w;
        nextPc[progLen] = progLen * 4 + offset;
        progLen++;
    endtask

    // sw rs2 into RAM word idx, recording the value it must carry
    task automatic storeAndExpect(int rs2, int idx, word value, int test);
        emit(sFormat(idx * 4, rs2, 0));
        expMem[idx]     = value;
        expValid[idx]   = 1'b1;
        testOfWord[idx] = test;
    endtask

    task automatic checkStore();
        int idx;
        idx = dataAddr[7:2];
        if (dataAddr > 32'd255 || !expValid[idx]) begin
            $display("unexpected store of %h to address %h", dataWdata, dataAddr);
            errs[curTest]++;
        end else begin
            seen[idx] = 1'b1;
            storeValue: assert (dataWdata === expMem[idx]) else begin
                $display("CHECK FAILED %s: word %0d expected %h actual %h",
                    names[testOfWord[idx]], idx, expMem[idx], dataWdata);
                errs[testOfWord[idx]]++;
            end
        end
    endtask

    always @(posedge CLK) begin
        if (!rstN) begin
            quietInReset: assert (dataWe === 1'b0) else begin
                $display("store enable raised while reset is asserted");
                errs[curTest]++;
            end
        end else begin
            pcSequence: assert (instrAddr === expNext) else begin
                $display("CHECK FAILED %s: instrAddr expected %h actual %h",
                    names[curTest], expNext, instrAddr);
                errs[curTest]++;
            end
            expNext = nextPc[instrAddr[7:2]];
            if (dataWe) begin
                checkStore();
            end
        end
    end

    initial begin
        #(10 * (10 + 2 * 64));
        $display("watchdog expired before the program reached its final instruction");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        word opA;
        word opB;
        word opC;
        word opD;
        int  linkPc;
        int  failed;
        void'($urandom(32'ha09fa6c2));
        opA = $urandom();
        opB = $urandom();
        opC = $urandom();
        opD = $urandom();
        progLen = 0;
        curTest = 0;
        failed  = 0;
        expNext = 32'h0;  // First fetch after reset
        for (int i = 0; i < 64; i++) begin
            rom[i]        = iFormat(i, 0, 0, 0, opIType);  // addi x0, x0, i
            nextPc[i]     = (i + 1) * 4;
            ram[i]        = 32'hc0de_0000 | i;
            expValid[i]   = 1'b0;
            seen[i]       = 1'b0;
            testOfWord[i] = 0;
        end
        for (int t = 0; t < 6; t++) begin
            errs[t] = 0;
        end
        ram[32] = opA;
        ram[33] = opB;
        ram[34] = opC;
        ram[35] = opD;

        // A store at address 0 is fetched for the whole of reset
        storeAndExpect(0, 20, 32'd0, 0);

        // Operands into x1..x4
        for (int r = 1; r <= 4; r++) begin
            emit(iFormat(124 + 4 * r, 0, 3'b010, r, opLoad));
        end
        testEnd[0] = progLen * 4;

        emit(rFormat(7'h00, 2, 1, 3'b000, 5));
        storeAndExpect(5, 0, opA + opB, 1);
        emit(rFormat(7'h20, 2, 1, 3'b000, 6));
        storeAndExpect(6, 1, opA - opB, 1);
        emit(rFormat(7'h00, 4, 3, 3'b111, 7));
        storeAndExpect(7, 2, opC & opD, 1);
        emit(rFormat(7'h00, 4, 3, 3'b110, 8));
        storeAndExpect(8, 3, opC | opD, 1);
        emit(rFormat(7'h00, 3, 1, 3'b100, 9));
        storeAndExpect(9, 4, opA ^ opC, 1);
        emit(rFormat(7'h00, 2, 1, 3'b010, 10));
        storeAndExpect(10, 5, {31'b0, $signed(opA) < $signed(opB)}, 1);
        emit(rFormat(7'h00, 1, 2, 3'b010, 11));
        storeAndExpect(11, 6, {31'b0, $signed(opB) < $signed(opA)}, 1);
        testEnd[1] = progLen * 4;

        emit(iFormat(-5, 1, 3'b000, 12, opIType));
        storeAndExpect(12, 7, opA + 32'hffff_fffb, 2);
        emit(iFormat(12'h0f0, 2, 3'b111, 13, opIType));
        storeAndExpect(13, 8, opB & 32'h0000_00f0, 2);
        emit(iFormat(-256, 3, 3'b110, 14, opIType));
        storeAndExpect(14, 9, opC | 32'hffff_ff00, 2);
        emit(iFormat(12'h7ff, 4, 3'b100, 15, opIType));
        storeAndExpect(15, 10, opD ^ 32'h0000_07ff, 2);
        emit(iFormat(-1, 1, 3'b010, 16, opIType));
        storeAndExpect(16, 11, {31'b0, $signed(opA) < -1}, 2);
        emit(uFormat(20'habcde, 17));
        storeAndExpect(17, 12, 32'habcd_e000, 2);
        testEnd[2] = progLen * 4;

        emit(iFormat(7, 0, 3'b000, 18, opIType));
        emit(iFormat(7, 0, 3'b000, 19, opIType));
        emit(iFormat(9, 0, 3'b000, 20, opIType));
        emitTaken(bFormat(8, 19, 18, 3'b000), 8);   // beq, equal
        emit(sFormat(104, 18, 0));                   // Skipped marker
        storeAndExpect(18, 13, 32'd7, 3);
        emit(bFormat(8, 20, 18, 3'b000));            // beq, unequal
        storeAndExpect(20, 14, 32'd9, 3);
        emitTaken(bFormat(8, 20, 18, 3'b001), 8);   // bne, unequal
        emit(sFormat(108, 20, 0));
        storeAndExpect(20, 15, 32'd9, 3);
        emit(bFormat(8, 19, 18, 3'b001));            // bne, equal
        storeAndExpect(18, 16, 32'd7, 3);
        testEnd[3] = progLen * 4;

        linkPc = progLen * 4 + 4;
        emitTaken(jFormat(12, 21), 12);
        emit(sFormat(112, 21, 0));
        emit(sFormat(116, 21, 0));
        storeAndExpect(21, 17, linkPc, 4);
        testEnd[4] = progLen * 4;

        emit(iFormat(123, 0, 3'b000, 0, opIType));  // Write to x0 is dropped
        storeAndExpect(0, 18, 32'd0, 5);
        // Custom-0 opcode shaped like add x18 and like a store to word 29
        emit({7'h00, 5'd20, 5'd20, 3'b000, 5'd18, 7'b0001011});
        emit({7'd3, 5'd20, 5'd0, 3'b010, 5'd20, 7'b0001011});
        storeAndExpect(18, 19, 32'd7, 5);
        testEnd[5] = progLen * 4;
        emitTaken(jFormat(0, 0), 0);                 // Halt loop

        for (int t = 0; t < 6; t++) begin
            @(negedge CLK);
            while (!rstN || instrAddr !== testEnd[t]) begin
                @(negedge CLK);
            end
            for (int w = 0; w < 64; w++) begin
                if (expValid[w] && testOfWord[w] == t && !seen[w]) begin
                    $display("expected store to RAM word %0d never happened", w);
                    errs[t]++;
                end
            end
            $display("test %-22s %s", names[t], (errs[t] == 0) ? "passed" : "failed");
            if (errs[t] != 0) begin
                failed++;
            end
            if (t < 5) begin
                curTest = t + 1;
            end
        end
        $display("%0d tests passed, %0d tests failed", 6 - failed, failed);
        if (failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- build.f
logic/cpuPkg.sv
logic/controlUnit.sv
logic/immGen.sv
logic/regFile.sv
logic/alu.sv
logic/pcUnit.sv
logic/singleCpu.sv
tb/clockGen.sv
tb/singleCpuTb.sv

//--- Bender.yml
package:
  name: singleCpu

sources:
  - logic/cpuPkg.sv
  - logic/controlUnit.sv
  - logic/immGen.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/pcUnit.sv
  - logic/singleCpu.sv
  - target: simulation
    files:
      - tb/clockGen.sv
      - tb/singleCpuTb.sv
